/* source/s4_pkg.sv */
// Stage 4 shared definitions
`default_nettype none

package s4_pkg;

  // ------------------------------------------------------------
  // Datapath widths
  // ------------------------------------------------------------

  // Pre-carry word, byte in 7..0 and carry into earlier bytes at 8
  localparam int word_width = 16;
  localparam int byte_width = 8;
  localparam int carry_bit  = 8;

  // Coder state handed over with a flush
  localparam int low_width = 24;
  localparam int cnt_width = 5;

  // Length of a held 0xFF run, longer runs get flagged
  localparam int run_width = 8;

  // ------------------------------------------------------------
  // Buffering
  // ------------------------------------------------------------

  localparam int in_fifo_depth  = 4;
  localparam int out_fifo_depth = 8;

  // ------------------------------------------------------------
  // APB register map
  // ------------------------------------------------------------

  localparam int apb_addr_width = 4;
  localparam int apb_data_width = 32;

  // Enable in bit 0, self-clearing clear in bit 1
  localparam logic [apb_addr_width-1:0] reg_ctrl        = 4'h0;
  // Done in bit 0, run overflow in bit 1, both sticky
  localparam logic [apb_addr_width-1:0] reg_status      = 4'h4;
  localparam logic [apb_addr_width-1:0] reg_byte_count  = 4'h8;
  localparam logic [apb_addr_width-1:0] reg_carry_count = 4'hC;

  // ------------------------------------------------------------
  // Chunk of pre-carry words
  // ------------------------------------------------------------

  // Count holds 0 to 2 valid words, word_1 goes first
  // Last is set only on the chunk built from a flush
  typedef struct packed {
    logic [1:0]            count;
    logic [word_width-1:0] word_1;
    logic [word_width-1:0] word_2;
    logic                  last;
  } s4_chunk_t;

endpackage

`default_nettype wire

/* source/s4_fifo.sv */
// Generic synchronous FIFO
`default_nettype none

module s4_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  wire           s4_clk,
  input  wire           rst_n,
  input  wire           wr_en,
  input  wire payload_t wr_data,
  input  wire           rd_en,
  output payload_t      rd_data,
  output logic          full,
  output logic          empty
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

  // Storage
  payload_t mem [depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  // Occupancy needs one bit more than the pointers
  logic [ptr_width:0]   level;
  logic                 do_wr;
  logic                 do_rd;

  // Writes into a full FIFO and reads from an empty one are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (level == (ptr_width+1)'(depth));
  assign empty = (level == '0);

  // Head of the queue is always visible
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge s4_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge s4_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the level alone
      if (do_wr && !do_rd) begin
        level <= level + 1'b1;
      end else if (do_rd && !do_wr) begin
        level <= level - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/final_bits_generator.sv */
// Final bits of a flushed stream
`default_nettype none

module final_bits_generator (
  input  wire [s4_pkg::low_width-1:0] low,
  input  wire [s4_pkg::cnt_width-1:0] cnt,
  output s4_pkg::s4_chunk_t           chunk
);

  // Top nine bits of low, the ninth one lands on the carry position
  logic [s4_pkg::carry_bit:0]    top_bits;
  // Next byte below, never has a carry
  logic [s4_pkg::byte_width-1:0] next_bits;

  assign top_bits  = low[s4_pkg::low_width-1 -: s4_pkg::carry_bit + 1];
  assign next_bits = low[s4_pkg::low_width-s4_pkg::carry_bit-2 -: s4_pkg::byte_width];

  always_comb begin
    chunk      = '0;
    chunk.last = 1'b1;
    // Low 23..15 into bits 8..0
    chunk.word_1 = {{(s4_pkg::word_width-s4_pkg::carry_bit-1){1'b0}}, top_bits};
    // Up to eight pending bits fit into one byte
    if (cnt <= s4_pkg::cnt_width'(8)) begin
      chunk.count = 2'd1;
    end else begin
      // Second byte from low 14..7
      chunk.count  = 2'd2;
      chunk.word_2 = {{(s4_pkg::word_width-s4_pkg::byte_width){1'b0}}, next_bits};
    end
  end

endmodule

`default_nettype wire

/* source/carry_resolver.sv */
// Carry resolver with pending byte and 0xFF run
`default_nettype none

module carry_resolver (
  input  wire                            s4_clk,
  input  wire                            rst_n,
  input  wire s4_pkg::s4_chunk_t         chunk,
  input  wire                            chunk_empty,
  input  wire                            out_full,
  input  wire                            clear,
  output logic                           chunk_pop,
  output logic                           byte_push,
  output logic [s4_pkg::byte_width-1:0]  byte_data,
  output logic                           byte_last,
  output logic                           carry_applied,
  output logic                           stream_done,
  output logic                           run_overflow,
  output logic                           busy
);

  // Walk words, then emit pending byte, then the run
  typedef enum logic [1:0] {
    st_word,
    st_pend,
    st_run
  } state_t;

  state_t                        state;
  // Words of the head chunk walked so far, 0 to 2
  logic [1:0]                    word_idx;
  logic                          has_pend;
  logic [s4_pkg::byte_width-1:0] pend_byte;
  logic [s4_pkg::run_width-1:0]  run_cnt;
  logic                          ovf_seen;

  // Snapshot of the held sequence being released
  logic [s4_pkg::byte_width-1:0] rel_byte;
  logic [s4_pkg::byte_width-1:0] rel_fill;
  logic [s4_pkg::run_width-1:0]  rel_left;
  logic                          rel_last;

  logic [s4_pkg::word_width-1:0] word;
  logic [s4_pkg::byte_width-1:0] new_byte;
  logic                          new_carry;
  logic                          word_valid;
  logic                          carry_rel;
  logic                          rel_go;
  logic                          grow;
  logic                          finish;

  // ------------------------------------------------------------
  // Word decode
  // ------------------------------------------------------------
  always_comb begin
    word      = word_idx[0] ? chunk.word_2 : chunk.word_1;
    new_byte  = word[s4_pkg::byte_width-1:0];
    new_carry = word[s4_pkg::carry_bit];

    // A word of the head chunk is still to be walked
    word_valid = (state == st_word) && !chunk_empty && (word_idx < chunk.count);
    // Flush chunk fully walked so whatever is held goes out
    finish = (state == st_word) && !chunk_empty && chunk.last &&
             (word_idx >= chunk.count);

    // A carry with nothing pending is dropped
    carry_rel = word_valid && new_carry && has_pend;
    // Carry or a settling byte frees the held sequence
    rel_go = word_valid && has_pend && (new_carry || new_byte != 8'hFF);
    // Plain 0xFF behind a pending byte extends the run
    grow   = word_valid && has_pend && !rel_go;

    // Pop on the last word or once a flush chunk is finished
    chunk_pop = finish ||
                ((state == st_word) && !chunk_empty && !chunk.last &&
                 (word_idx + 2'd1 >= chunk.count));
  end

  // ------------------------------------------------------------
  // Release side
  // ------------------------------------------------------------
  always_comb begin
    byte_push = (state != st_word) && !out_full;
    byte_data = (state == st_pend) ? rel_byte : rel_fill;
    // Final byte of the stream when the release ends here
    byte_last = rel_last &&
                (((state == st_pend) && (rel_left == '0)) ||
                 ((state == st_run) && (rel_left == s4_pkg::run_width'(1))));
  end

  assign carry_applied = carry_rel;
  // Flush with nothing pending ends without any byte
  assign stream_done   = (byte_push && byte_last) || (finish && !has_pend);
  assign run_overflow  = grow && (run_cnt == '1) && !ovf_seen;
  assign busy          = rel_last || (!chunk_empty && chunk.last);

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge s4_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_word;
      word_idx <= 2'd0;
      has_pend <= 1'b0;
      run_cnt  <= '0;
      rel_left <= '0;
      rel_last <= 1'b0;
      ovf_seen <= 1'b0;
    end else begin
      if (chunk_pop) begin
        word_idx <= 2'd0;
      end else if (word_valid) begin
        word_idx <= word_idx + 2'd1;
      end

      if (grow) begin
        // Run saturates and the overflow flag reports it
        if (run_cnt != '1) begin
          run_cnt <= run_cnt + 1'b1;
        end
      end else if (word_valid) begin
        has_pend <= 1'b1;
        run_cnt  <= '0;
      end

      if (rel_go) begin
        rel_left <= run_cnt;
        rel_last <= 1'b0;
        state    <= st_pend;
      end else if (finish) begin
        has_pend <= 1'b0;
        run_cnt  <= '0;
        if (has_pend) begin
          rel_left <= run_cnt;
          rel_last <= 1'b1;
          state    <= st_pend;
        end
      end else if (byte_push) begin
        if (state == st_pend) begin
          state <= (rel_left == '0) ? st_word : st_run;
        end else begin
          rel_left <= rel_left - 1'b1;
          if (rel_left == s4_pkg::run_width'(1)) begin
            state <= st_word;
          end
        end
        if (byte_last) begin
          rel_last <= 1'b0;
        end
      end

      // One overflow pulse per stream until cleared
      if (clear || finish) begin
        ovf_seen <= 1'b0;
      end else if (run_overflow) begin
        ovf_seen <= 1'b1;
      end
    end
  end

  // Byte payloads
  always_ff @(posedge s4_clk) begin
    if (word_valid && !grow) begin
      pend_byte <= new_byte;
    end
    if (rel_go) begin
      rel_byte <= carry_rel ? pend_byte + 1'b1 : pend_byte;
      // Carry turns the whole run into zeros
      rel_fill <= carry_rel ? 8'h00 : 8'hFF;
    end else if (finish) begin
      rel_byte <= pend_byte;
      rel_fill <= 8'hFF;
    end
  end

endmodule

`default_nettype wire

/* source/s4_apb_regs.sv */
// Stage 4 APB registers
`default_nettype none

module s4_apb_regs (
  input  wire                                s4_clk,
  input  wire                                rst_n,
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire [s4_pkg::apb_addr_width-1:0]   paddr,
  input  wire [s4_pkg::apb_data_width-1:0]   pwdata,
  input  wire                                byte_written,
  input  wire                                carry_applied,
  input  wire                                stream_done,
  input  wire                                run_overflow,
  output logic [s4_pkg::apb_data_width-1:0]  prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               enable,
  output logic                               clear
);

  logic                              access;
  logic                              mapped;
  logic                              ctrl_wr;
  logic                              done_flag;
  logic                              ovf_flag;
  logic [s4_pkg::apb_data_width-1:0] byte_count;
  logic [s4_pkg::apb_data_width-1:0] carry_count;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  assign access = psel && penable;
  assign mapped = (paddr == s4_pkg::reg_ctrl) || (paddr == s4_pkg::reg_status) ||
                  (paddr == s4_pkg::reg_byte_count) || (paddr == s4_pkg::reg_carry_count);
  // Status and counters are read only
  assign ctrl_wr = access && pwrite && (paddr == s4_pkg::reg_ctrl);

  // No wait states
  assign pready  = 1'b1;
  assign pslverr = access && !mapped;

  // Read data in the access cycle, clear bit always reads 0
  always_comb begin
    prdata = '0;
    case (paddr)
      s4_pkg::reg_ctrl:        prdata[0] = enable;
      s4_pkg::reg_status:      prdata[1:0] = {ovf_flag, done_flag};
      s4_pkg::reg_byte_count:  prdata = byte_count;
      s4_pkg::reg_carry_count: prdata = carry_count;
      default:                 prdata = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_ff @(posedge s4_clk or negedge rst_n) begin
    if (!rst_n) begin
      enable <= 1'b0;
      clear  <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        enable <= pwdata[0];
      end
      // Single cycle pulse
      clear <= ctrl_wr && pwdata[1];
    end
  end

  // ------------------------------------------------------------
  // Status and counters
  // ------------------------------------------------------------
  always_ff @(posedge s4_clk or negedge rst_n) begin
    if (!rst_n) begin
      done_flag   <= 1'b0;
      ovf_flag    <= 1'b0;
      byte_count  <= '0;
      carry_count <= '0;
    end else if (clear) begin
      done_flag   <= 1'b0;
      ovf_flag    <= 1'b0;
      byte_count  <= '0;
      carry_count <= '0;
    end else begin
      // Sticky until the next clear
      done_flag <= done_flag || stream_done;
      ovf_flag  <= ovf_flag || run_overflow;
      // Counters wrap at 32 bits
      if (byte_written) begin
        byte_count <= byte_count + 1'b1;
      end
      if (carry_applied) begin
        carry_count <= carry_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/stage_4.sv */
// Stage 4 carry propagation top level
`default_nettype none

module stage_4 (
  input  wire                                s4_clk,
  input  wire                                rst_n,
  // Arrival of pre-carry words
  input  wire                                in_valid,
  output logic                               in_ready,
  input  wire [1:0]                          in_flag,
  input  wire [s4_pkg::word_width-1:0]       in_word_1,
  input  wire [s4_pkg::word_width-1:0]       in_word_2,
  // Flush of the coder state
  input  wire                                flush,
  input  wire [s4_pkg::low_width-1:0]        flush_low,
  input  wire [s4_pkg::cnt_width-1:0]        flush_cnt,
  // Finished bytes
  output logic                               out_valid,
  output logic [s4_pkg::byte_width-1:0]      out_byte,
  output logic                               out_last,
  input  wire                                out_ready,
  // APB
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire [s4_pkg::apb_addr_width-1:0]   paddr,
  input  wire [s4_pkg::apb_data_width-1:0]   pwdata,
  output logic [s4_pkg::apb_data_width-1:0]  prdata,
  output logic                               pready,
  output logic                               pslverr
);

  s4_pkg::s4_chunk_t             gen_chunk;
  s4_pkg::s4_chunk_t             mux_chunk;
  s4_pkg::s4_chunk_t             head_chunk;
  logic                          in_wr;
  logic                          in_full;
  logic                          in_empty;
  logic                          chunk_pop;
  logic                          flush_hold;

  logic                          byte_push;
  logic [s4_pkg::byte_width-1:0] byte_data;
  logic                          byte_last;
  logic [s4_pkg::byte_width:0]   out_head;
  logic                          out_full;
  logic                          out_empty;

  logic                          carry_applied;
  logic                          stream_done;
  logic                          run_overflow;
  logic                          busy;
  logic                          enable;
  logic                          clear;

  // ------------------------------------------------------------
  // Input mux and acceptance
  // ------------------------------------------------------------

  // Flush wins over an arrival chunk in the same cycle
  always_comb begin
    if (flush) begin
      mux_chunk = gen_chunk;
    end else begin
      mux_chunk.count  = in_flag;
      mux_chunk.word_1 = in_word_1;
      mux_chunk.word_2 = in_word_2;
      mux_chunk.last   = 1'b0;
    end
  end

  // Closed from an accepted flush until its last byte is queued
  assign in_ready = enable && !in_full && !flush_hold && !busy;
  assign in_wr    = in_ready && (flush || in_valid);

  always_ff @(posedge s4_clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_hold <= 1'b0;
    end else if (in_wr && flush) begin
      flush_hold <= 1'b1;
    end else if (stream_done) begin
      flush_hold <= 1'b0;
    end
  end

  // Byte and its last marker leave together
  assign out_valid = !out_empty;
  assign out_byte  = out_head[s4_pkg::byte_width-1:0];
  // Stale marker of an empty FIFO stays hidden
  assign out_last  = out_head[s4_pkg::byte_width] && !out_empty;

  // ------------------------------------------------------------
  // Instances
  // ------------------------------------------------------------
  final_bits_generator i_final_bits (
    .low   (flush_low),
    .cnt   (flush_cnt),
    .chunk (gen_chunk)
  );

  s4_fifo #(
    .payload_t (s4_pkg::s4_chunk_t),
    .depth     (s4_pkg::in_fifo_depth)
  ) i_in_fifo (
    .s4_clk  (s4_clk),
    .rst_n   (rst_n),
    .wr_en   (in_wr),
    .wr_data (mux_chunk),
    .rd_en   (chunk_pop),
    .rd_data (head_chunk),
    .full    (in_full),
    .empty   (in_empty)
  );

  carry_resolver i_resolver (
    .s4_clk        (s4_clk),
    .rst_n         (rst_n),
    .chunk         (head_chunk),
    .chunk_empty   (in_empty),
    .out_full      (out_full),
    .clear         (clear),
    .chunk_pop     (chunk_pop),
    .byte_push     (byte_push),
    .byte_data     (byte_data),
    .byte_last     (byte_last),
    .carry_applied (carry_applied),
    .stream_done   (stream_done),
    .run_overflow  (run_overflow),
    .busy          (busy)
  );

  s4_fifo #(
    .payload_t (logic [s4_pkg::byte_width:0]),
    .depth     (s4_pkg::out_fifo_depth)
  ) i_out_fifo (
    .s4_clk  (s4_clk),
    .rst_n   (rst_n),
    .wr_en   (byte_push),
    .wr_data ({byte_last, byte_data}),
    .rd_en   (out_valid && out_ready),
    .rd_data (out_head),
    .full    (out_full),
    .empty   (out_empty)
  );

  s4_apb_regs i_regs (
    .s4_clk        (s4_clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .byte_written  (byte_push),
    .carry_applied (carry_applied),
    .stream_done   (stream_done),
    .run_overflow  (run_overflow),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .enable        (enable),
    .clear         (clear)
  );

endmodule

`default_nettype wire

/* tb/stage_4_sva.sv */
// Stage 4 handshake assertions
`default_nettype none

module stage_4_sva (
  input wire                              s4_clk,
  input wire                              rst_n,
  input wire                              in_ready,
  input wire                              out_valid,
  input wire                              out_ready,
  input wire [s4_pkg::byte_width-1:0]     out_byte,
  input wire                              out_last,
  input wire                              pready
);

  // Output byte and marker hold under back-pressure
  out_hold_a : assert property (@(posedge s4_clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> ($stable(out_byte) && $stable(out_last)))
    else $error("output changed while stalled");

  // Last marker only travels with a valid byte
  out_last_a : assert property (@(posedge s4_clk) disable iff (!rst_n)
    out_last |-> out_valid)
    else $error("out_last without out_valid");

  // Input closed during reset
  in_reset_a : assert property (@(posedge s4_clk)
    !rst_n |-> !in_ready)
    else $error("in_ready high in reset");

  // No APB wait states
  pready_a : assert property (@(posedge s4_clk) disable iff (!rst_n)
    pready)
    else $error("pready low");

endmodule

bind stage_4 stage_4_sva i_sva (
  .s4_clk    (s4_clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_byte  (out_byte),
  .out_last  (out_last),
  .pready    (pready)
);

`default_nettype wire

/* tb/stage_4_tb.sv */
// Stage 4 testbench
`default_nettype none

module stage_4_tb;

  logic        s4_clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  logic [1:0]  in_flag;
  logic [15:0] in_word_1;
  logic [15:0] in_word_2;
  logic        flush;
  logic [23:0] flush_low;
  logic [4:0]  flush_cnt;
  logic        out_valid;
  logic [7:0]  out_byte;
  logic        out_last;
  logic        out_ready;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          seed = 87394;
  int          errors = 0;
  int          checks = 0;
  int          timeout_cycles = 4000;
  // Reference model state
  logic [7:0]  exp_q[$];
  logic [7:0]  rx_q[$];
  logic        rx_last_q[$];
  int          tail_ff;
  int          carry_total = 0;
  int          byte_total = 0;
  logic [31:0] rd;
  logic        err;

  stage_4 i_stage_4 (.*);

  initial s4_clk = 1'b0;
  always #2 s4_clk = ~s4_clk;

  // ------------------------------------------------------------
  // Output collection with random back-pressure
  // ------------------------------------------------------------
  always @(negedge s4_clk) begin
    out_ready = ($random(seed) & 3) != 0;
    // Handshake completes on the coming rising edge
    if (rst_n && out_valid && out_ready) begin
      rx_q.push_back(out_byte);
      rx_last_q.push_back(out_last);
    end
  end

  task automatic check(input logic [31:0] act, input logic [31:0] exp, input string msg);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at time %0t: %s, got %0h, expected %0h", $time, msg, act, exp);
    end
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge s4_clk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge s4_clk);
    penable = 1'b1;
    @(negedge s4_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic slverr);
    @(negedge s4_clk);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge s4_clk);
    penable = 1'b1;
    // Sample in the middle of the access phase
    #1;
    data    = prdata;
    slverr  = pslverr;
    @(negedge s4_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp, input string msg);
    logic [31:0] d;
    logic        e;
    apb_read(addr, d, e);
    check(d, exp, msg);
    check(e, 0, "pslverr on mapped register");
  endtask

  // Append a word and ripple its carry back through 0xFF bytes
  task automatic model_word(input logic [15:0] w);
    int i;
    if (w[8] && exp_q.size() > 0) begin
      carry_total++;
      i = exp_q.size() - 1;
      while (i >= 0 && exp_q[i] == 8'hFF) begin
        exp_q[i] = 8'h00;
        i--;
      end
      if (i >= 0) exp_q[i] = exp_q[i] + 1'b1;
    end
    exp_q.push_back(w[7:0]);
    tail_ff = (w[7:0] == 8'hFF) ? tail_ff + 1 : 0;
  endtask

  // Bias toward 0xFF and carries with a plain first word
  task automatic rand_word(output logic [15:0] w);
    logic [7:0] b;
    b = $random(seed);
    if (exp_q.size() > 0 && tail_ff < 100 && ($random(seed) & 3) == 0) b = 8'hFF;
    else if (b == 8'hFF) b = 8'hFE;
    w = {8'h00, b};
    if (exp_q.size() > 0 && b != 8'hFF && ($random(seed) & 3) == 0) w[8] = 1'b1;
    model_word(w);
  endtask

  task automatic send_in(input logic is_flush, input logic [1:0] flag, input logic [15:0] w1,
                         input logic [15:0] w2, input logic [23:0] low, input logic [4:0] cnt);
    int t;
    t = 0;
    @(negedge s4_clk);
    in_valid  = !is_flush;
    flush     = is_flush;
    in_flag   = flag;
    in_word_1 = w1;
    in_word_2 = w2;
    flush_low = low;
    flush_cnt = cnt;
    while (!in_ready && t < timeout_cycles) begin
      @(negedge s4_clk);
      t++;
    end
    if (t >= timeout_cycles) begin
      errors++;
      $display("Timeout: in_ready never rose to accept a chunk");
    end
    @(negedge s4_clk);
    in_valid = 1'b0;
    flush    = 1'b0;
  endtask

  // Flush of one final word, or of two when two_words is set
  task automatic run_stream(input logic two_words);
    int          words;
    int          t;
    logic [1:0]  f;
    logic [15:0] a;
    logic [15:0] b;
    logic [23:0] low;
    logic [4:0]  cnt;
    exp_q.delete();
    rx_q.delete();
    rx_last_q.delete();
    words   = 0;
    tail_ff = 0;
    // At least eight bytes per stream
    while (words < 8) begin
      f = $unsigned($random(seed)) % 3;
      a = $random(seed);
      b = $random(seed);
      if (f >= 1) rand_word(a);
      if (f == 2) rand_word(b);
      words += f;
      send_in(1'b0, f, a, b, 24'h0, 5'h0);
    end
    low = $random(seed);
    if (two_words) begin
      cnt = 5'd9 + $unsigned($random(seed)) % 15;
    end else begin
      cnt = $unsigned($random(seed)) % 9;
    end
    // A carry from bit 23 never rides on a 0xFF byte
    if (low[23] && low[22:15] == 8'hFF) low[15] = 1'b0;
    model_word({7'h00, low[23:15]});
    if (cnt > 8) model_word({8'h00, low[14:7]});
    send_in(1'b1, 2'd0, 16'h0, 16'h0, low, cnt);
    t = 0;
    while (!(rx_last_q.size() > 0 && rx_last_q[$]) && t < timeout_cycles) begin
      @(negedge s4_clk);
      t++;
    end
    if (t >= timeout_cycles) begin
      errors++;
      $display("Timeout: the final byte of a stream never arrived");
    end
    check(rx_q.size(), exp_q.size(), "stream byte count");
    for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
      check(rx_q[i], exp_q[i], "stream byte");
      check(rx_last_q[i], (i == exp_q.size() - 1), "out_last position");
    end
    byte_total += exp_q.size();
  endtask

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_flag   = '0;
    in_word_1 = '0;
    in_word_2 = '0;
    flush     = 1'b0;
    flush_low = '0;
    flush_cnt = '0;
    out_ready = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    repeat (4) @(posedge s4_clk);
    @(negedge s4_clk);
    rst_n = 1'b1;

    // Disabled after reset
    repeat (5) begin
      @(negedge s4_clk);
      check(in_ready, 0, "in_ready while disabled");
    end
    read_reg(s4_pkg::reg_ctrl, 0, "ctrl after reset");
    read_reg(s4_pkg::reg_status, 0, "status after reset");
    read_reg(s4_pkg::reg_byte_count, 0, "byte count after reset");
    read_reg(s4_pkg::reg_carry_count, 0, "carry count after reset");
    apb_write(s4_pkg::reg_ctrl, 32'h1);

    // Alternate one-word and two-word flushes
    repeat (3) begin
      run_stream(1'b0);
      run_stream(1'b1);
    end

    read_reg(s4_pkg::reg_status, 32'h1, "status done");
    read_reg(s4_pkg::reg_byte_count, byte_total, "byte count");
    read_reg(s4_pkg::reg_carry_count, carry_total, "carry count");
    // Read-only registers and an unmapped address
    apb_write(s4_pkg::reg_byte_count, 32'h1234);
    apb_write(s4_pkg::reg_status, 32'h0);
    read_reg(s4_pkg::reg_byte_count, byte_total, "byte count after write");
    read_reg(s4_pkg::reg_status, 32'h1, "status after write");
    apb_read(4'h2, rd, err);
    check(err, 1, "pslverr on unmapped address");
    // Clear keeps enable
    apb_write(s4_pkg::reg_ctrl, 32'h3);
    read_reg(s4_pkg::reg_ctrl, 32'h1, "ctrl after clear");
    read_reg(s4_pkg::reg_status, 0, "status after clear");
    read_reg(s4_pkg::reg_byte_count, 0, "byte count after clear");
    read_reg(s4_pkg::reg_carry_count, 0, "carry count after clear");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* stage_4.f */
source/s4_pkg.sv
source/s4_fifo.sv
source/final_bits_generator.sv
source/carry_resolver.sv
source/s4_apb_regs.sv
source/stage_4.sv
tb/stage_4_sva.sv
tb/stage_4_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the stage 4 simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module stage_4_tb -f stage_4.f -o stage_4_sim \
  && ./obj_dir/stage_4_sim | tee /dev/stderr | grep -q "TEST PASSED" \
  && exit 0 \
  || exit 1
